//--- design/systolic_pkg.sv
`default_nettype none

package systolic_pkg;

    // ------------------------------
    // Datapath widths
    // ------------------------------
    localparam int DATA_W = 4;          // One A or B element
    localparam int ACC_W  = 9;          // One C element, holds 2 * 15 * 15 = 450

    // ------------------------------
    // Burst schedule
    // ------------------------------
    localparam int COMPUTE_STEPS = 5;   // Steps in one compute burst

    typedef logic [2:0] step_t;         // Step index inside a burst

    // Controller states
    typedef enum logic [1:0] {
        IDLE,                           // Nothing loading or computing
        LOAD_ROW0,                      // Head weights, top row
        LOAD_ROW1,                      // Head weights, bottom row
        COMPUTE                         // Streaming A of the head job
    } ctrl_state_t;

    // Steps at which C elements sit at the bottom of the array
    localparam step_t CAP_C11_STEP = 3'd2;  // C11 on column 0
    localparam step_t CAP_MID_STEP = 3'd3;  // C21 on column 0, C12 on column 1
    localparam step_t CAP_C22_STEP = 3'd4;  // C22 on column 1

endpackage

`default_nettype wire

//--- design/step_counter.sv
`timescale 1ns/1ps
`default_nettype none

module step_counter
    import systolic_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  compute_en,
    output step_t step,
    output logic  last
);

    localparam step_t LAST_STEP = step_t'(COMPUTE_STEPS - 1);

    // Final step of the burst, only while computing
    assign last = compute_en && (step == LAST_STEP);

    // Burst timer, wraps to 0 after the final step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step <= '0;
        end else if (compute_en) begin
            step <= last ? '0 : step_t'(step + 3'd1);
        end
    end

    // Never past the end of the schedule
    a_step_range: assert property (@(posedge clk) disable iff (!rst_n)
        step <= LAST_STEP);

    // Controller only drops compute_en after a full burst
    a_idle_at_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !compute_en |-> step == '0);

endmodule

`default_nettype wire

//--- design/job_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module job_ctrl
    import systolic_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    input  logic last,
    output logic full,
    output logic wr_en,
    output logic wr_slot,
    output logic w_slot,
    output logic load_row0,
    output logic load_row1,
    output logic head_slot,
    output logic compute_en
);

    ctrl_state_t state;
    logic [1:0]  slot_valid;     // Slot holds an accepted job
    logic [1:0]  slot_loaded;    // Slot's B sits in its weight buffer
    logic        bg_row0_done;   // Background load has written row 0
    logic        other_slot;
    logic        bg_load;
    logic        next_ready;

    // ------------------------------
    // Slot allocation
    // ------------------------------
    assign other_slot = ~head_slot;
    assign full       = &slot_valid;                 // Both slots taken
    assign wr_en      = in_valid & ~full;
    assign wr_slot    = slot_valid[head_slot] ? other_slot : head_slot;

    assign compute_en = (state == COMPUTE);

    // Waiting job whose B is not in its buffer yet
    assign bg_load = compute_en & slot_valid[other_slot] & ~slot_loaded[other_slot];

    // Weight load strobes, slot s always writes buffer s
    always_comb begin
        load_row0 = 1'b0;
        load_row1 = 1'b0;
        w_slot    = head_slot;
        case (state)
            LOAD_ROW0: load_row0 = 1'b1;
            LOAD_ROW1: load_row1 = 1'b1;
            COMPUTE: begin
                w_slot    = other_slot;              // Background, never the head
                load_row0 = bg_load & ~bg_row0_done;
                load_row1 = bg_load & bg_row0_done;
            end
            default: begin
                w_slot = head_slot;                  // Idle, no weight traffic
            end
        endcase
    end

    // Next job can start straight after this burst
    assign next_ready = slot_loaded[other_slot] | (compute_en & load_row1);

    // ------------------------------
    // State and slot bookkeeping
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            slot_valid   <= '0;
            slot_loaded  <= '0;
            head_slot    <= 1'b0;
            bg_row0_done <= 1'b0;
        end else begin
            if (wr_en)
                slot_valid[wr_slot] <= 1'b1;         // Latch job into free slot

            case (state)
                IDLE: begin
                    // Start on the accepting edge or with a stranded head
                    if (wr_en || slot_valid[head_slot])
                        state <= LOAD_ROW0;
                end
                LOAD_ROW0: state <= LOAD_ROW1;
                LOAD_ROW1: begin
                    slot_loaded[head_slot] <= 1'b1;
                    state                  <= COMPUTE;
                end
                COMPUTE: begin
                    if (load_row0)
                        bg_row0_done <= 1'b1;
                    if (load_row1) begin
                        bg_row0_done            <= 1'b0;
                        slot_loaded[other_slot] <= 1'b1;
                    end
                    if (last) begin
                        slot_valid[head_slot]  <= 1'b0;   // Free the finished job
                        slot_loaded[head_slot] <= 1'b0;
                        head_slot              <= other_slot;
                        if (!next_ready) begin
                            state        <= IDLE;    // Load the waiting job first
                            bg_row0_done <= 1'b0;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Row 1 always follows row 0 into the same buffer
    a_row_order: assert property (@(posedge clk) disable iff (!rst_n)
        load_row1 |-> $past(load_row0) && ($past(w_slot) == w_slot));

    // Loads never land on a buffer that already holds a job's weights
    a_bg_target: assert property (@(posedge clk) disable iff (!rst_n)
        (load_row0 || load_row1) |-> !slot_loaded[w_slot]);

endmodule

`default_nettype wire

//--- design/job_store.sv
`timescale 1ns/1ps
`default_nettype none

module job_store
    import systolic_pkg::*;
#(
    parameter int DATA_W = systolic_pkg::DATA_W
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [DATA_W-1:0] a11,
    input  logic [DATA_W-1:0] a12,
    input  logic [DATA_W-1:0] a21,
    input  logic [DATA_W-1:0] a22,
    input  logic [DATA_W-1:0] b11,
    input  logic [DATA_W-1:0] b12,
    input  logic [DATA_W-1:0] b21,
    input  logic [DATA_W-1:0] b22,
    input  logic              wr_en,
    input  logic              wr_slot,
    input  logic              w_slot,
    input  logic              load_row1,
    input  logic              head_slot,
    input  logic              compute_en,
    input  step_t             step,
    output logic [DATA_W-1:0] a_row0,
    output logic [DATA_W-1:0] a_row1,
    output logic [DATA_W-1:0] b_col0,
    output logic [DATA_W-1:0] b_col1
);

    // Two slots of A and B, indexed by slot
    logic [1:0][DATA_W-1:0] a11_q, a12_q, a21_q, a22_q;
    logic [1:0][DATA_W-1:0] b11_q, b12_q, b21_q, b22_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a11_q <= '0;
            a12_q <= '0;
            a21_q <= '0;
            a22_q <= '0;
            b11_q <= '0;
            b12_q <= '0;
            b21_q <= '0;
            b22_q <= '0;
        end else if (wr_en) begin
            a11_q[wr_slot] <= a11;
            a12_q[wr_slot] <= a12;
            a21_q[wr_slot] <= a21;
            a22_q[wr_slot] <= a22;
            b11_q[wr_slot] <= b11;
            b12_q[wr_slot] <= b12;
            b21_q[wr_slot] <= b21;
            b22_q[wr_slot] <= b22;
        end
    end

    // ------------------------------
    // A streaming, row 1 skewed by one step
    // ------------------------------
    always_comb begin
        a_row0 = '0;
        a_row1 = '0;
        if (compute_en) begin
            case (step)
                3'd0: a_row0 = a11_q[head_slot];
                3'd1: begin
                    a_row0 = a21_q[head_slot];
                    a_row1 = a12_q[head_slot];
                end
                3'd2: a_row1 = a22_q[head_slot];
                default: a_row0 = '0;        // Drain steps
            endcase
        end
    end

    // B row of the slot being loaded
    assign b_col0 = load_row1 ? b21_q[w_slot] : b11_q[w_slot];
    assign b_col1 = load_row1 ? b22_q[w_slot] : b12_q[w_slot];

endmodule

`default_nettype wire

//--- design/pe.sv
`timescale 1ns/1ps
`default_nettype none

module pe
    import systolic_pkg::*;
#(
    parameter int DATA_W  = systolic_pkg::DATA_W,
    parameter int ACC_W   = systolic_pkg::ACC_W,
    parameter bit TOP_ROW = 1'b0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [DATA_W-1:0] a_in,
    input  logic [ACC_W-1:0]  psum_in,
    input  logic [DATA_W-1:0] w_in,
    input  logic              load_w,
    input  logic              w_slot,
    input  logic              head_slot,
    input  logic              compute_en,
    output logic [DATA_W-1:0] a_out,
    output logic [ACC_W-1:0]  psum_out
);

    logic [DATA_W-1:0]   w_q [2];     // One weight buffer per job slot
    logic [2*DATA_W-1:0] prod;
    logic [ACC_W-1:0]    psum_base;

    // Weight buffers, written by slot
    always_ff @(posedge clk) begin
        if (load_w)
            w_q[w_slot] <= w_in;
    end

    assign prod      = a_in * w_q[head_slot];        // Active buffer of the head job
    assign psum_base = TOP_ROW ? '0 : psum_in;       // Top row starts the column sum

    // ------------------------------
    // MAC, A goes right, sum goes down
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_out    <= '0;
            psum_out <= '0;
        end else if (compute_en) begin
            a_out    <= a_in;
            psum_out <= psum_base + ACC_W'(prod);
        end
    end

endmodule

`default_nettype wire

//--- design/result_capture.sv
`timescale 1ns/1ps
`default_nettype none

module result_capture
    import systolic_pkg::*;
#(
    parameter int ACC_W = systolic_pkg::ACC_W
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             compute_en,
    input  step_t            step,
    input  logic             last,
    input  logic [ACC_W-1:0] col0_psum,
    input  logic [ACC_W-1:0] col1_psum,
    output logic [ACC_W-1:0] c11,
    output logic [ACC_W-1:0] c12,
    output logic [ACC_W-1:0] c21,
    output logic [ACC_W-1:0] c22,
    output logic             out_valid
);

    // ------------------------------
    // Pick C off the bottom PE row
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            c11       <= '0;
            c12       <= '0;
            c21       <= '0;
            c22       <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= last;                           // Pulse after the final step
            if (compute_en) begin
                if (step == CAP_C11_STEP)
                    c11 <= col0_psum;
                if (step == CAP_MID_STEP) begin
                    c21 <= col0_psum;                    // Second row of column 0
                    c12 <= col1_psum;                    // First row of column 1
                end
                if (step == CAP_C22_STEP)
                    c22 <= col1_psum;
            end
        end
    end

    // Bursts are at least five cycles apart
    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid);

endmodule

`default_nettype wire

//--- design/systolic_top.sv
`timescale 1ns/1ps
`default_nettype none

module systolic_top
    import systolic_pkg::*;
#(
    parameter int DATA_W = systolic_pkg::DATA_W,
    parameter int ACC_W  = systolic_pkg::ACC_W
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [DATA_W-1:0] a11,
    input  logic [DATA_W-1:0] a12,
    input  logic [DATA_W-1:0] a21,
    input  logic [DATA_W-1:0] a22,
    input  logic [DATA_W-1:0] b11,
    input  logic [DATA_W-1:0] b12,
    input  logic [DATA_W-1:0] b21,
    input  logic [DATA_W-1:0] b22,
    input  logic              in_valid,
    output logic [ACC_W-1:0]  c11,
    output logic [ACC_W-1:0]  c12,
    output logic [ACC_W-1:0]  c21,
    output logic [ACC_W-1:0]  c22,
    output logic              out_valid,
    output logic              full
);

    // Control
    logic  wr_en, wr_slot, w_slot, head_slot;
    logic  load_row0, load_row1, compute_en, last;
    step_t step;

    // Array datapath
    logic [DATA_W-1:0] a_row0, a_row1, b_col0, b_col1;
    logic [DATA_W-1:0] a_r0c1, a_r1c1;               // A forwarded to column 1
    logic [ACC_W-1:0]  psum_r0c0, psum_r0c1;         // Top row sums going down
    logic [ACC_W-1:0]  col0_psum, col1_psum;         // Bottom of each column

    job_ctrl u_ctrl (
        .clk, .rst_n, .in_valid, .last, .full, .wr_en, .wr_slot, .w_slot,
        .load_row0, .load_row1, .head_slot, .compute_en
    );

    step_counter u_steps (.clk, .rst_n, .compute_en, .step, .last);

    job_store #(.DATA_W(DATA_W)) u_store (
        .clk, .rst_n, .a11, .a12, .a21, .a22, .b11, .b12, .b21, .b22,
        .wr_en, .wr_slot, .w_slot, .load_row1, .head_slot, .compute_en, .step,
        .a_row0, .a_row1, .b_col0, .b_col1
    );

    // ------------------------------
    // 2x2 PE array
    // ------------------------------
    pe #(.DATA_W(DATA_W), .ACC_W(ACC_W), .TOP_ROW(1'b1)) pe_r0c0 (
        .clk, .rst_n, .a_in(a_row0), .psum_in('0), .w_in(b_col0),
        .load_w(load_row0), .w_slot, .head_slot, .compute_en,
        .a_out(a_r0c1), .psum_out(psum_r0c0)
    );

    pe #(.DATA_W(DATA_W), .ACC_W(ACC_W), .TOP_ROW(1'b1)) pe_r0c1 (
        .clk, .rst_n, .a_in(a_r0c1), .psum_in('0), .w_in(b_col1),
        .load_w(load_row0), .w_slot, .head_slot, .compute_en,
        .a_out(), .psum_out(psum_r0c1)               // Right edge, A leaves here
    );

    pe #(.DATA_W(DATA_W), .ACC_W(ACC_W), .TOP_ROW(1'b0)) pe_r1c0 (
        .clk, .rst_n, .a_in(a_row1), .psum_in(psum_r0c0), .w_in(b_col0),
        .load_w(load_row1), .w_slot, .head_slot, .compute_en,
        .a_out(a_r1c1), .psum_out(col0_psum)
    );

    pe #(.DATA_W(DATA_W), .ACC_W(ACC_W), .TOP_ROW(1'b0)) pe_r1c1 (
        .clk, .rst_n, .a_in(a_r1c1), .psum_in(psum_r0c1), .w_in(b_col1),
        .load_w(load_row1), .w_slot, .head_slot, .compute_en,
        .a_out(), .psum_out(col1_psum)
    );

    result_capture #(.ACC_W(ACC_W)) u_capture (
        .clk, .rst_n, .compute_en, .step, .last, .col0_psum, .col1_psum,
        .c11, .c12, .c21, .c22, .out_valid
    );

endmodule

`default_nettype wire

//--- tests/systolic_tb.sv
`timescale 1ns/1ps
`default_nettype none

module systolic_tb
    import systolic_pkg::*;
;

    logic              clk;
    logic              rst_n;
    logic [DATA_W-1:0] a11, a12, a21, a22;
    logic [DATA_W-1:0] b11, b12, b21, b22;
    logic              in_valid;
    logic [ACC_W-1:0]  c11, c12, c21, c22;
    logic              out_valid;
    logic              full;

    logic [4*ACC_W-1:0] expect_q [$];    // Expected {c11, c12, c21, c22}, oldest first
    logic [4*ACC_W-1:0] exp_c;           // Entry popped by the monitor
    int                 ignored_count;   // in_valid seen while full

    systolic_top #(.DATA_W(DATA_W), .ACC_W(ACC_W)) dut (
        .clk, .rst_n, .a11, .a12, .a21, .a22, .b11, .b12, .b21, .b22,
        .in_valid, .c11, .c12, .c21, .c22, .out_valid, .full
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;                // 10 ns period

    // ------------------------------
    // Failure reporting and checks
    // ------------------------------
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual)
            stop_with_failure($sformatf("FAILED %s expected %0d actual %0d",
                                        name, expected, actual));
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    // Element order {a11, a12, a21, a22, b11, b12, b21, b22}
    function automatic logic [4*ACC_W-1:0] model_product(input logic [8*DATA_W-1:0] elems);
        logic [DATA_W-1:0] m11, m12, m21, m22;
        logic [DATA_W-1:0] n11, n12, n21, n22;
        logic [ACC_W-1:0]  p11, p12, p21, p22;
        {m11, m12, m21, m22, n11, n12, n21, n22} = elems;
        p11 = ACC_W'(m11) * ACC_W'(n11) + ACC_W'(m12) * ACC_W'(n21);   // Row 1 x col 1
        p12 = ACC_W'(m11) * ACC_W'(n12) + ACC_W'(m12) * ACC_W'(n22);
        p21 = ACC_W'(m21) * ACC_W'(n11) + ACC_W'(m22) * ACC_W'(n21);
        p22 = ACC_W'(m21) * ACC_W'(n12) + ACC_W'(m22) * ACC_W'(n22);   // Row 2 x col 2
        return {p11, p12, p21, p22};
    endfunction

    function automatic logic [8*DATA_W-1:0] random_elems();
        logic [8*DATA_W-1:0] v;
        for (int i = 0; i < 8; i++)
            v[i*DATA_W +: DATA_W] = DATA_W'($urandom_range((1 << DATA_W) - 1, 0));
        return v;
    endfunction

    // ------------------------------
    // Stimulus
    // ------------------------------
    // Called just after a falling edge, returns at the next one
    task automatic drive_cycle(input logic valid, input logic [8*DATA_W-1:0] elems);
        {a11, a12, a21, a22, b11, b12, b21, b22} = elems;
        in_valid = valid;
        if (valid) begin
            if (!full) begin
                expect_q.push_back(model_product(elems));  // Accepted on the next rising edge
            end else begin
                ignored_count++;                           // Dropped by the DUT
            end
        end
        @(negedge clk);
    endtask

    // Density in percent of cycles that carry in_valid
    task automatic run_random_phase(input int cycles, input int density_pct);
        logic v;
        for (int n = 0; n < cycles; n++) begin
            v = int'($urandom_range(99, 0)) < density_pct;
            drive_cycle(v, random_elems());
        end
    endtask

    task automatic wait_drain(input int max_cycles, input string phase);
        int n;
        n = 0;
        in_valid = 1'b0;
        while (expect_q.size() != 0 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (expect_q.size() != 0)
            stop_with_failure($sformatf("Timeout in %s, %0d results did not arrive",
                                        phase, expect_q.size()));
    endtask

    // ------------------------------
    // Output monitor
    // ------------------------------
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (expect_q.size() == 0) begin
                stop_with_failure("out_valid pulsed with no accepted job outstanding");
            end else begin
                exp_c = expect_q.pop_front();                 // Acceptance order
                check_value("c11", int'(exp_c[4*ACC_W-1 -: ACC_W]), int'(c11));
                check_value("c12", int'(exp_c[3*ACC_W-1 -: ACC_W]), int'(c12));
                check_value("c21", int'(exp_c[2*ACC_W-1 -: ACC_W]), int'(c21));
                check_value("c22", int'(exp_c[ACC_W-1 -: ACC_W]), int'(c22));
            end
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        void'($urandom(32'ha9a8));
        ignored_count  = 0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        {a11, a12, a21, a22, b11, b12, b21, b22} = '0;

        repeat (16) @(posedge clk);
        check_value("reset_out_valid", 0, int'(out_valid));
        check_value("reset_full", 0, int'(full));
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("idle_out_valid", 0, int'(out_valid));
        check_value("idle_full", 0, int'(full));
        check_value("idle_c11", 0, int'(c11));
        check_value("idle_c12", 0, int'(c12));
        check_value("idle_c21", 0, int'(c21));
        check_value("idle_c22", 0, int'(c22));

        // Isolated jobs, array empty each time
        for (int j = 0; j < 6; j++) begin
            drive_cycle(1'b1, random_elems());
            wait_drain(40, "isolated job");
        end

        // Largest operands, 2 * 15 * 15 per element
        drive_cycle(1'b1, '1);
        wait_drain(40, "all-15 job");
        check_value("max_c11", 450, int'(c11));
        check_value("max_c12", 450, int'(c12));
        check_value("max_c21", 450, int'(c21));
        check_value("max_c22", 450, int'(c22));

        // Sparse, dense, then saturated to hold full high
        run_random_phase(300, 20);
        run_random_phase(300, 60);
        run_random_phase(300, 100);
        wait_drain(200, "random stream drain");

        // Nothing outstanding, any later pulse is a stray result
        repeat (20) @(negedge clk);

        check_value("full_seen", 1, int'(ignored_count > 0));
        check_value("final_full", 0, int'(full));

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
design/systolic_pkg.sv
design/step_counter.sv
design/job_ctrl.sv
design/job_store.sv
design/pe.sv
design/result_capture.sv
design/systolic_top.sv
tests/systolic_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= systolic_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= No errors

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
